// File: list.f
+incdir+.
dac_bus_pkg.sv
dac_serial_pkg.sv
dac_sclk_gen.sv
dac_bus_decode.sv
dac_channel.sv
dac_bus_return.sv
dac_array_top.sv
dac_array_tb.sv

// File: Bender.yml
package:
  name: dac_array

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dac_bus_pkg.sv
      - dac_serial_pkg.sv
      - dac_sclk_gen.sv
      - dac_bus_decode.sv
      - dac_channel.sv
      - dac_bus_return.sv
      - dac_array_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dac_array_tb.sv

// File: dac_array_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_settings.svh"

module dac_array_tb;

	localparam int NCH = `DAC_NUM_CH;
	// upper bound for any single wait in clocks
	localparam int WAIT_MAX = 600;

	logic                  clk;
	logic                  rst;
	logic                  cyc;
	logic                  stb;
	logic                  we;
	logic [`DAC_ADR_W-1:0] adr;
	logic [15:0]           dat_w;
	logic [15:0]           dat_r;
	logic                  ack;
	logic                  sclk;
	logic [NCH-1:0]        sync;
	logic [NCH-1:0]        sdata;

	dac_array_top u_dac_array_top (
		.clk_i   (clk),
		.rst_i   (rst),
		.cyc_i   (cyc),
		.stb_i   (stb),
		.we_i    (we),
		.adr_i   (adr),
		.dat_i   (dat_w),
		.dat_o   (dat_r),
		.ack_o   (ack),
		.sclk_o  (sclk),
		.sync_o  (sync),
		.sdata_o (sdata)
	);

	// 8 ns system clock
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ============================================================
	// helpers
	// ============================================================

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			fail_run("value check failed");
		end
	endtask

	// wire frame per the part is two zero bits then mode then code
	function automatic logic [15:0] frame_of(input logic [15:0] word);
		return {2'b00, word[13:12], word[11:0]};
	endfunction

	function automatic logic [`DAC_ADR_W-1:0] chan_adr(input int ch);
		return `DAC_ADR_W'(dac_bus_pkg::CODE_BASE + ch);
	endfunction

	// single write cycle held until ack
	task automatic write_word(input logic [`DAC_ADR_W-1:0] a, input logic [15:0] d);
		int n;
		@(negedge clk);
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = 1'b1;
		adr   = a;
		dat_w = d;
		n     = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > WAIT_MAX) begin
				fail_run($sformatf("timeout waiting for write ack at address %0d", a));
			end
		end while (ack !== 1'b1);
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
	endtask

	// single read cycle with data taken together with ack
	task automatic read_word(input logic [`DAC_ADR_W-1:0] a, output logic [15:0] d);
		int n;
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we  = 1'b0;
		adr = a;
		n   = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > WAIT_MAX) begin
				fail_run($sformatf("timeout waiting for read ack at address %0d", a));
			end
		end while (ack !== 1'b1);
		d   = dat_r;
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	// collect one frame from a channel
	// a bit is taken at each sclk fall seen while sync is low
	task automatic capture_frame(input int ch, output logic [15:0] frame);
		int   n;
		int   bits;
		logic prev;
		n = 0;
		while (sync[ch] !== 1'b0) begin
			@(negedge clk);
			n++;
			if (n > WAIT_MAX) begin
				fail_run($sformatf("timeout waiting for sync low on channel %0d", ch));
			end
		end
		prev  = sclk;
		bits  = 0;
		frame = '0;
		n     = 0;
		while (sync[ch] === 1'b0) begin
			@(negedge clk);
			n++;
			if (n > WAIT_MAX) begin
				fail_run($sformatf("sync stuck low on channel %0d", ch));
			end
			if (sync[ch] === 1'b0 && prev === 1'b1 && sclk === 1'b0) begin
				frame = {frame[14:0], sdata[ch]};
				bits++;
			end
			prev = sclk;
		end
		if (bits != 16) begin
			fail_run($sformatf("channel %0d sent %0d bits instead of 16", ch, bits));
		end
	endtask

	// masked sync lines must stay high for a while
	task automatic watch_quiet(input logic [NCH-1:0] mask, input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			if ((sync & mask) !== mask) begin
				fail_run("sync went low on a channel that got no write");
			end
		end
	endtask

	// poll status until every channel reports idle
	task automatic wait_idle();
		logic [15:0] st;
		int          n;
		n  = 0;
		st = 16'hffff;
		while (st !== 16'h0000) begin
			read_word(dac_bus_pkg::STATUS_ADR, st);
			n++;
			if (n > WAIT_MAX) begin
				fail_run("channels never went idle");
			end
		end
	endtask

	// ============================================================
	// directed tests
	// ============================================================

	task automatic reset_state();
		logic [15:0] st;
		check("reset_state", {NCH{1'b1}}, sync);
		check("reset_state", 0, ack);
		check("reset_state", 0, sdata);
		check("reset_state", 0, sclk);
		read_word(dac_bus_pkg::STATUS_ADR, st);
		check("reset_state", 0, st);
	endtask

	task automatic single_frame();
		logic [15:0] word;
		logic [15:0] got;
		word        = 16'($urandom);
		word[13:12] = dac_serial_pkg::PD_NORMAL;
		fork
			write_word(chan_adr(0), word);
			capture_frame(0, got);
			watch_quiet(~NCH'(1), 200);
		join
		check("single_frame", frame_of(word), got);
	endtask

	task automatic power_modes();
		logic [15:0] word;
		logic [15:0] got;
		logic [15:0] rd;
		for (int m = 0; m < 4; m++) begin
			word        = 16'($urandom);
			word[13:12] = 2'(m);
			fork
				write_word(chan_adr(1), word);
				capture_frame(1, got);
			join
			// mode field on the wire first, then the whole frame
			check("power_modes", m, got[13:12]);
			check("power_modes", frame_of(word), got);
			// readback holds mode and code of the last write
			read_word(chan_adr(1), rd);
			check("power_modes", frame_of(word), rd);
		end
	endtask

	task automatic all_channels();
		logic [15:0] words [4];
		logic [15:0] got [4];
		for (int i = 0; i < 4; i++) begin
			words[i] = 16'($urandom);
		end
		fork
			begin
				for (int i = 0; i < 4; i++) begin
					write_word(chan_adr(i), words[i]);
				end
			end
			capture_frame(0, got[0]);
			capture_frame(1, got[1]);
			capture_frame(2, got[2]);
			capture_frame(3, got[3]);
		join
		for (int i = 0; i < 4; i++) begin
			check("all_channels", frame_of(words[i]), got[i]);
		end
	endtask

	task automatic busy_backpressure();
		logic [15:0] word_a;
		logic [15:0] word_b;
		logic [15:0] got_a;
		logic [15:0] got_b;
		logic [15:0] st;
		logic        a_done;
		word_a = 16'($urandom);
		word_b = 16'($urandom);
		a_done = 1'b0;
		wait_idle();
		fork
			begin
				capture_frame(2, got_a);
				a_done = 1'b1;
				capture_frame(2, got_b);
			end
			begin
				write_word(chan_adr(2), word_a);
				read_word(dac_bus_pkg::STATUS_ADR, st);
				check("busy_backpressure", 16'h0004, st);
				// stalls until the first frame is out
				write_word(chan_adr(2), word_b);
				check("busy_backpressure", 1, a_done);
			end
		join
		check("busy_backpressure", frame_of(word_a), got_a);
		check("busy_backpressure", frame_of(word_b), got_b);
	endtask

	task automatic unmapped_access();
		logic [15:0] rd;
		wait_idle();
		read_word(`DAC_ADR_W'(12), rd);
		check("unmapped_access", 0, rd);
		fork
			write_word(`DAC_ADR_W'(13), 16'h3abc);
			watch_quiet({NCH{1'b1}}, 200);
		join
	endtask

	// ============================================================
	// main sequence
	// ============================================================
	initial begin
		logic [31:0] seed_ret;
		rst      = 1'b1;
		cyc      = 1'b0;
		stb      = 1'b0;
		we       = 1'b0;
		adr      = '0;
		dat_w    = '0;
		seed_ret = $urandom(32'h7f8d_e81b);
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		reset_state();
		single_frame();
		power_modes();
		all_channels();
		busy_backpressure();
		unmapped_access();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dac_array_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_settings.svh"

module dac_array_top (
	input  wire logic                  clk_i,
	input  wire logic                  rst_i,
	input  wire logic                  cyc_i,
	input  wire logic                  stb_i,
	input  wire logic                  we_i,
	input  wire logic [`DAC_ADR_W-1:0] adr_i,
	input  wire logic [15:0]           dat_i,
	output logic [15:0]                dat_o,
	output logic                       ack_o,
	output logic                       sclk_o,
	output logic [`DAC_NUM_CH-1:0]     sync_o,
	output logic [`DAC_NUM_CH-1:0]     sdata_o
);

	localparam int FB = dac_serial_pkg::FRAME_BITS;

	logic                      sclk_rise;
	logic [`DAC_NUM_CH-1:0]    wr_stb;
	logic [`DAC_NUM_CH-1:0]    rd_code;
	logic                      rd_status;
	logic                      unmapped_ack;
	logic [`DAC_NUM_CH-1:0]    ch_ack;
	logic [`DAC_NUM_CH-1:0]    ch_busy;
	logic [`DAC_NUM_CH*FB-1:0] last_word;

	// one serial clock shared by every channel
	dac_sclk_gen u_sclk_gen (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.sclk_o      (sclk_o),
		.sclk_rise_o (sclk_rise)
	);

	dac_bus_decode u_bus_decode (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.cyc_i          (cyc_i),
		.stb_i          (stb_i),
		.we_i           (we_i),
		.adr_i          (adr_i),
		.wr_stb_o       (wr_stb),
		.rd_code_o      (rd_code),
		.rd_status_o    (rd_status),
		.unmapped_ack_o (unmapped_ack)
	);

	// ============================================================
	// channel shifters, each with its own sync and data line
	// ============================================================
	for (genvar i = 0; i < `DAC_NUM_CH; i++) begin : g_ch
		dac_channel u_channel (
			.clk_i       (clk_i),
			.rst_i       (rst_i),
			.wr_stb_i    (wr_stb[i]),
			.sclk_rise_i (sclk_rise),
			.dat_i       (dat_i),
			.ack_o       (ch_ack[i]),
			.busy_o      (ch_busy[i]),
			.last_word_o (last_word[i*FB +: FB]),
			.sync_o      (sync_o[i]),
			.sdata_o     (sdata_o[i])
		);
	end

	dac_bus_return u_bus_return (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.cyc_i          (cyc_i),
		.stb_i          (stb_i),
		.ch_ack_i       (ch_ack),
		.busy_i         (ch_busy),
		.last_word_i    (last_word),
		.rd_code_i      (rd_code),
		.rd_status_i    (rd_status),
		.unmapped_ack_i (unmapped_ack),
		.dat_o          (dat_o),
		.ack_o          (ack_o)
	);

endmodule

`default_nettype wire

// File: dac_bus_return.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_settings.svh"

module dac_bus_return (
	input  wire logic                      clk_i,
	input  wire logic                      rst_i,
	input  wire logic                      cyc_i,
	input  wire logic                      stb_i,
	input  wire logic [`DAC_NUM_CH-1:0]    ch_ack_i,
	input  wire logic [`DAC_NUM_CH-1:0]    busy_i,
	input  wire logic [`DAC_NUM_CH*16-1:0] last_word_i,
	input  wire logic [`DAC_NUM_CH-1:0]    rd_code_i,
	input  wire logic                      rd_status_i,
	input  wire logic                      unmapped_ack_i,
	output logic [15:0]                    dat_o,
	output logic                           ack_o
);

	dac_bus_pkg::status_t status;
	logic [15:0]          rd_mux;
	logic                 rd_ack_q;

	assign status.zero = '0;
	assign status.busy = busy_i;

	// read strobes are one-hot, so an or-tree is enough
	// unmapped reads fall through as zero
	always_comb begin
		rd_mux = '0;
		if (rd_status_i) begin
			rd_mux = status;
		end
		for (int i = 0; i < `DAC_NUM_CH; i++) begin
			if (rd_code_i[i]) begin
				rd_mux = rd_mux | last_word_i[i*16 +: 16];
			end
		end
	end

	// read ack and data land one clock after the request
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_ack_q <= 1'b0;
		end else begin
			rd_ack_q <= rd_status_i | (|rd_code_i);
		end
	end

	always_ff @(posedge clk_i) begin
		dat_o <= rd_mux;
	end

	// the bus only sees ack while the cycle is still up
	assign ack_o = cyc_i & stb_i & ((|ch_ack_i) | rd_ack_q | unmapped_ack_i);

endmodule

`default_nettype wire

// File: dac_channel.sv
`timescale 1ns/1ps
`default_nettype none

module dac_channel (
	input  wire logic        clk_i,
	input  wire logic        rst_i,
	input  wire logic        wr_stb_i,
	input  wire logic        sclk_rise_i,
	input  wire logic [15:0] dat_i,
	output logic             ack_o,
	output logic             busy_o,
	output logic [15:0]      last_word_o,
	output logic             sync_o,
	output logic             sdata_o
);

	localparam int FB = dac_serial_pkg::FRAME_BITS;
	localparam int CB = dac_serial_pkg::CODE_BITS;
	localparam int MB = dac_serial_pkg::MODE_BITS;
	localparam int CNT_W = $clog2(FB);

	dac_serial_pkg::shift_state_t state;
	dac_serial_pkg::pd_mode_t     mode;
	logic [CNT_W-1:0]             cnt;
	logic [FB-1:0]                shreg;
	logic [FB-1:0]                frame;

	// mode bits sit right above the code in the host word
	assign mode = dac_serial_pkg::pd_mode_t'(dat_i[CB+MB-1:CB]);

	// pad zeros, mode, code, msb first on the wire
	assign frame = {{dac_serial_pkg::PAD_BITS{1'b0}}, mode, dat_i[CB-1:0]};

	assign busy_o  = (state != dac_serial_pkg::IDLE);
	assign sdata_o = shreg[FB-1];

	// ============================================================
	// frame FSM, advanced only on sclk rising edges
	// ============================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state       <= dac_serial_pkg::IDLE;
			ack_o       <= 1'b0;
			sync_o      <= 1'b1;
			cnt         <= '0;
			shreg       <= '0;
			last_word_o <= '0;
		end else begin
			// ack holds until the host drops the strobe
			if (!wr_stb_i) begin
				ack_o <= 1'b0;
			end
			case (state)
				dac_serial_pkg::IDLE: begin
					// a write only lands here, busy channels stall the bus
					if (wr_stb_i) begin
						shreg       <= frame;
						last_word_o <= frame;
						ack_o       <= 1'b1;
						state       <= dac_serial_pkg::LOAD;
					end
				end
				dac_serial_pkg::LOAD: begin
					// open the frame, msb is already on sdata
					if (sclk_rise_i) begin
						sync_o <= 1'b0;
						cnt    <= '0;
						state  <= dac_serial_pkg::SHIFT;
					end
				end
				dac_serial_pkg::SHIFT: begin
					if (sclk_rise_i) begin
						shreg <= {shreg[FB-2:0], 1'b0};
						cnt   <= cnt + CNT_W'(1);
						// last bit has had its falling edge, close the frame
						if (cnt == CNT_W'(FB - 1)) begin
							sync_o <= 1'b1;
							state  <= dac_serial_pkg::TERM;
						end
					end
				end
				dac_serial_pkg::TERM: begin
					// one sclk period of sync high before the next frame
					if (sclk_rise_i) begin
						state <= dac_serial_pkg::IDLE;
					end
				end
				default: begin
					state <= dac_serial_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: dac_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_settings.svh"

module dac_bus_decode (
	input  wire logic                  clk_i,
	input  wire logic                  rst_i,
	input  wire logic                  cyc_i,
	input  wire logic                  stb_i,
	input  wire logic                  we_i,
	input  wire logic [`DAC_ADR_W-1:0] adr_i,
	output logic [`DAC_NUM_CH-1:0]     wr_stb_o,
	output logic [`DAC_NUM_CH-1:0]     rd_code_o,
	output logic                       rd_status_o,
	output logic                       unmapped_ack_o
);

	logic                   req;
	logic [`DAC_NUM_CH-1:0] ch_hit;
	logic                   status_hit;
	logic                   miss;

	// a request is live while both cyc and stb are high
	assign req = cyc_i & stb_i;

	// one compare per channel code register
	always_comb begin
		for (int i = 0; i < `DAC_NUM_CH; i++) begin
			ch_hit[i] = (adr_i == `DAC_ADR_W'(dac_bus_pkg::CODE_BASE + i));
		end
	end

	assign status_hit = (adr_i == dac_bus_pkg::STATUS_ADR);

	// strobes are plain levels, they last as long as the request
	assign wr_stb_o    = ch_hit & {`DAC_NUM_CH{req & we_i}};
	assign rd_code_o   = ch_hit & {`DAC_NUM_CH{req & ~we_i}};
	assign rd_status_o = req & ~we_i & status_hit;

	// status is read-only, so a write there counts as unmapped too
	assign miss = req & ~(|ch_hit) & ~(status_hit & ~we_i);

	// unmapped accesses get an ack one clock later so the bus never hangs
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			unmapped_ack_o <= 1'b0;
		end else begin
			unmapped_ack_o <= miss;
		end
	end

endmodule

`default_nettype wire

// File: dac_sclk_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "dac_settings.svh"

module dac_sclk_gen (
	input  wire logic clk_i,
	input  wire logic rst_i,
	output logic      sclk_o,
	output logic      sclk_rise_o
);

	// counter must be able to hold DAC_PRESCALE itself
	localparam int CNT_W = $clog2(`DAC_PRESCALE + 1);

	logic [CNT_W-1:0] ps_cnt;

	// prescale counter runs 1..DAC_PRESCALE, then sclk flips
	// rise pulse lines up with the first clock of sclk high
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ps_cnt      <= CNT_W'(1);
			sclk_o      <= 1'b0;
			sclk_rise_o <= 1'b0;
		end else begin
			// default is no edge this clock
			sclk_rise_o <= 1'b0;
			if (ps_cnt == CNT_W'(`DAC_PRESCALE)) begin
				ps_cnt <= CNT_W'(1);
				sclk_o <= ~sclk_o;
				// only the low to high transition paces the shifters
				sclk_rise_o <= ~sclk_o;
			end else begin
				ps_cnt <= ps_cnt + CNT_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

// File: dac_serial_pkg.sv
`default_nettype none

package dac_serial_pkg;

	// ============================================================
	// dac121s101 frame layout
	// ============================================================

	// full frame, shifted msb first
	localparam int FRAME_BITS = 16;
	// dac code field, lowest bits of the frame
	localparam int CODE_BITS = 12;
	// power-down mode field, just above the code
	localparam int MODE_BITS = 2;
	// leading don't-care bits, always sent as zero
	localparam int PAD_BITS = FRAME_BITS - MODE_BITS - CODE_BITS;

	// channel shifter states
	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		SHIFT,
		TERM
	} shift_state_t;

	// output stage behaviour selected by the mode bits
	typedef enum logic [MODE_BITS-1:0] {
		PD_NORMAL = 2'b00,
		PD_1K_GND = 2'b01,
		PD_100K_GND = 2'b10,
		PD_HIGH_Z = 2'b11
	} pd_mode_t;

endpackage

`default_nettype wire

// File: dac_bus_pkg.sv
`default_nettype none

`include "dac_settings.svh"

package dac_bus_pkg;

	// width of a host data word
	localparam int WORD_BITS = 16;

	// ============================================================
	// register map, word addresses
	// ============================================================

	// channel n code register lives at CODE_BASE + n
	localparam logic [`DAC_ADR_W-1:0] CODE_BASE = `DAC_ADR_W'd0;

	// read-only busy flags
	localparam logic [`DAC_ADR_W-1:0] STATUS_ADR = `DAC_ADR_W'd8;

	// status word as seen by the host
	// busy flags sit in the low bits, the rest reads as zero
	typedef struct packed {
		logic [WORD_BITS-`DAC_NUM_CH-1:0] zero;
		logic [`DAC_NUM_CH-1:0]           busy;
	} status_t;

endpackage

`default_nettype wire

// File: dac_settings.svh
`ifndef DAC_SETTINGS_SVH
`define DAC_SETTINGS_SVH

// ============================================================
// build-time sizing for the dac array
// ============================================================

// number of serial dac channels behind the host port
`define DAC_NUM_CH 4

// host word address width
`define DAC_ADR_W 4

// system clocks per sclk half period
// the dac121s101 tops out at 30 MHz sclk, pick this to stay below
`define DAC_PRESCALE 3

`endif
